// ==== Makefile ====
# Verilator build and run of the token engine testbench

SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_token_engine: src.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_token_engine -f src.f

run: obj_dir/Vtb_token_engine
	./obj_dir/Vtb_token_engine > sim.log
	cat sim.log
	grep -q "^Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== src.f ====
src/token_pkg.sv
src/pass_ctrl.sv
src/weight_loader.sv
src/lane_fifo_ctrl.sv
src/glb_arbiter.sv
src/token_engine.sv
verif/tb_token_engine.sv

// ==== src/glb_arbiter.sv ====
// --------------------
// single GLB port shared by fixed priority: opsum writes, weight, ifmap
// word addresses in, byte addresses out, read data routed to its owner
// --------------------
`timescale 1ns/1ps

module glb_arbiter import token_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              weight_req_i,
    input  logic [WORD_W-1:0]                 weight_addr_i,
    input  logic [NUM_LANES-1:0]              ifmap_req_i,
    input  logic [NUM_LANES-1:0][WORD_W-1:0]  ifmap_addr_i,
    input  logic [NUM_LANES-1:0]              opsum_req_i,
    input  logic [NUM_LANES-1:0][WORD_W-1:0]  opsum_addr_i,
    input  logic [NUM_LANES-1:0][WORD_W-1:0]  opsum_data_i,
    output logic                              weight_grant_o,
    output logic [NUM_LANES-1:0]              ifmap_grant_o,
    output logic [NUM_LANES-1:0]              opsum_grant_o,
    output logic                              weight_rd_valid_o,
    output logic [NUM_LANES-1:0]              ifmap_rd_valid_o,
    output logic [WORD_W-1:0]                 glb_addr_o,
    output logic [3:0]                        glb_web_o,
    output logic [WORD_W-1:0]                 glb_wdata_o
);

    glb_src_t          rd_src;     // owner of this cycle's read
    logic [LANE_W-1:0] rd_lane;
    glb_src_t          own_src;    // owner of the data on glb_rdata_i
    logic [LANE_W-1:0] own_lane;

    always_comb begin
        logic [WORD_W-1:0] word_addr;
        logic              taken;

        weight_grant_o = 1'b0;
        ifmap_grant_o  = '0;
        opsum_grant_o  = '0;
        glb_web_o      = WEB_READ;
        glb_wdata_o    = '0;
        word_addr      = '0;
        taken          = 1'b0;
        rd_src         = SRC_NONE;
        rd_lane        = '0;

        for (int l = 0; l < NUM_LANES; l++) begin
            if (!taken && opsum_req_i[l]) begin
                taken            = 1'b1;
                opsum_grant_o[l] = 1'b1;
                word_addr        = opsum_addr_i[l];
                glb_web_o        = WEB_WRITE;   // full-word write
                glb_wdata_o      = opsum_data_i[l];
            end
        end

        if (!taken && weight_req_i) begin
            taken          = 1'b1;
            weight_grant_o = 1'b1;
            word_addr      = weight_addr_i;
            rd_src         = SRC_WEIGHT;
        end

        for (int l = 0; l < NUM_LANES; l++) begin
            if (!taken && ifmap_req_i[l]) begin
                taken            = 1'b1;
                ifmap_grant_o[l] = 1'b1;
                word_addr        = ifmap_addr_i[l];
                rd_src           = SRC_IFMAP;
                rd_lane          = LANE_W'(l);
            end
        end

        glb_addr_o = word_addr << 2;   // byte address
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            own_src  <= SRC_NONE;
            own_lane <= '0;
        end else begin
            own_src  <= rd_src;
            own_lane <= rd_lane;
        end
    end

    assign weight_rd_valid_o = own_src == SRC_WEIGHT;
    assign ifmap_rd_valid_o  = (own_src == SRC_IFMAP) ? (NUM_LANES'(1) << own_lane) : '0;

endmodule

// ==== src/lane_fifo_ctrl.sv ====
// --------------------
// per-lane ifmap reads into the FIFOs during fill and opsum pops
// written back to the GLB during drain, one output row per call
// --------------------
`timescale 1ns/1ps

module lane_fifo_ctrl import token_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              fill_phase_i,
    input  logic                              drain_phase_i,
    input  logic [CNT_W-1:0]                  row_idx_i,
    input  logic [CNT_W-1:0]                  in_c_i,
    input  logic [CNT_W-1:0]                  out_r_i,
    input  logic [WORD_W-1:0]                 ifmap_base_i,
    input  logic [WORD_W-1:0]                 opsum_base_i,
    input  logic [NUM_LANES-1:0]              ifmap_full_i,
    input  logic [NUM_LANES-1:0]              opsum_empty_i,
    input  logic [NUM_LANES-1:0][WORD_W-1:0]  opsum_pop_data_i,
    input  logic [NUM_LANES-1:0]              rd_grant_i,
    input  logic [NUM_LANES-1:0]              wr_grant_i,
    input  logic [NUM_LANES-1:0]              rd_valid_i,
    input  logic [WORD_W-1:0]                 glb_rdata_i,
    output logic [NUM_LANES-1:0]              rd_req_o,
    output logic [NUM_LANES-1:0]              wr_req_o,
    output logic [NUM_LANES-1:0][WORD_W-1:0]  rd_addr_o,
    output logic [NUM_LANES-1:0][WORD_W-1:0]  wr_addr_o,
    output logic [NUM_LANES-1:0][WORD_W-1:0]  wr_data_o,
    output logic [NUM_LANES-1:0]              ifmap_push_o,
    output logic [WORD_W-1:0]                 ifmap_push_data_o,
    output logic [NUM_LANES-1:0]              opsum_pop_o,
    output logic                              fill_done_o,
    output logic                              drain_done_o
);

    logic [CNT_W-1:0]     rd_cnt   [NUM_LANES];   // reads granted this row
    logic [CNT_W-1:0]     push_cnt [NUM_LANES];   // words pushed this row
    logic [NUM_LANES-1:0] in_flight;
    logic [NUM_LANES-1:0] drained;
    logic [NUM_LANES-1:0] lane_filled;

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_filled[l] = push_cnt[l] == in_c_i;

            // full must already count the in-flight word
            rd_req_o[l] = fill_phase_i && (rd_cnt[l] != in_c_i) && !in_flight[l]
                          && !ifmap_full_i[l];
            // lane l holds rows l*out_r .. l*out_r+out_r-1, in_c words each
            rd_addr_o[l] = ifmap_base_i
                           + (WORD_W'(l) * WORD_W'(out_r_i) + WORD_W'(row_idx_i))
                             * WORD_W'(in_c_i)
                           + WORD_W'(rd_cnt[l]);

            wr_req_o[l]  = drain_phase_i && !drained[l] && !opsum_empty_i[l];  // FWFT head
            wr_addr_o[l] = opsum_base_i + WORD_W'(row_idx_i) * WORD_W'(NUM_LANES)
                           + WORD_W'(l);
            wr_data_o[l] = opsum_pop_data_i[l];
        end
    end

    // data comes back one cycle after the grant
    assign ifmap_push_o      = rd_valid_i;
    assign ifmap_push_data_o = glb_rdata_i;
    assign opsum_pop_o       = wr_grant_i;   // pop on the write cycle

    assign fill_done_o  = fill_phase_i && (&lane_filled);
    assign drain_done_o = drain_phase_i && (&drained);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            in_flight <= '0;
            drained   <= '0;
            for (int l = 0; l < NUM_LANES; l++) begin
                rd_cnt[l]   <= '0;
                push_cnt[l] <= '0;
            end
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (!fill_phase_i) begin
                    rd_cnt[l]    <= '0;   // cleared for the next row
                    push_cnt[l]  <= '0;
                    in_flight[l] <= 1'b0;
                end else begin
                    if (rd_grant_i[l]) begin
                        rd_cnt[l]    <= rd_cnt[l] + CNT_W'(1);
                        in_flight[l] <= 1'b1;
                    end
                    if (rd_valid_i[l]) begin
                        push_cnt[l]  <= push_cnt[l] + CNT_W'(1);
                        in_flight[l] <= 1'b0;
                    end
                end

                if (!drain_phase_i)
                    drained[l] <= 1'b0;
                else if (wr_grant_i[l])
                    drained[l] <= 1'b1;   // one opsum word per lane per row
            end
        end
    end

endmodule

// ==== src/pass_ctrl.sv ====
// --------------------
// pass sequencer: weight load, then fill / drain once per output row
// start is taken only in idle, done is a one-cycle pulse
// --------------------
`timescale 1ns/1ps

module pass_ctrl import token_pkg::*; (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             pass_start_i,
    input  logic [CNT_W-1:0] out_r_i,
    input  logic             weight_done_i,
    input  logic             fill_done_i,
    input  logic             drain_done_i,
    output logic             weight_phase_o,
    output logic             fill_phase_o,
    output logic             drain_phase_o,
    output logic [CNT_W-1:0] row_idx_o,
    output logic             pass_done_o
);

    pass_state_t      state;
    pass_state_t      state_nxt;
    logic [CNT_W-1:0] row_q;
    logic             last_row;

    assign last_row = (row_q + CNT_W'(1)) == out_r_i;

    always_comb begin
        state_nxt = state;
        case (state)
            PASS_IDLE:   if (pass_start_i) state_nxt = PASS_WEIGHT;
            PASS_WEIGHT: begin
                if (weight_done_i)
                    state_nxt = (out_r_i == '0) ? PASS_DONE : PASS_FILL;  // no rows at all
            end
            PASS_FILL:   if (fill_done_i) state_nxt = PASS_DRAIN;
            PASS_DRAIN: begin
                if (drain_done_i)
                    state_nxt = last_row ? PASS_DONE : PASS_FILL;
            end
            PASS_DONE:   state_nxt = PASS_IDLE;
            default:     state_nxt = PASS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= PASS_IDLE;
            row_q <= '0;
        end else begin
            state <= state_nxt;
            if (state == PASS_IDLE)
                row_q <= '0;
            else if (state == PASS_DRAIN && drain_done_i && !last_row)
                row_q <= row_q + CNT_W'(1);   // next output row
        end
    end

    assign weight_phase_o = state == PASS_WEIGHT;
    assign fill_phase_o   = state == PASS_FILL;
    assign drain_phase_o  = state == PASS_DRAIN;
    assign row_idx_o      = row_q;
    assign pass_done_o    = state == PASS_DONE;   // done lasts exactly one cycle

endmodule

// ==== src/token_engine.sv ====
// --------------------
// token engine top: pass FSM, weight loader, lane FIFO control and
// GLB arbiter; one pass per start pulse
// --------------------
`timescale 1ns/1ps

module token_engine import token_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              pass_start_i,
    input  logic [WORD_W-1:0]                 weight_base_i,
    input  logic [WORD_W-1:0]                 ifmap_base_i,
    input  logic [WORD_W-1:0]                 opsum_base_i,
    input  logic [CNT_W-1:0]                  in_c_i,
    input  logic [CNT_W-1:0]                  out_r_i,
    input  logic [WORD_W-1:0]                 glb_rdata_i,
    input  logic [NUM_LANES-1:0]              ifmap_full_i,
    input  logic [NUM_LANES-1:0]              opsum_empty_i,
    input  logic [NUM_LANES-1:0][WORD_W-1:0]  opsum_pop_data_i,
    output logic                              pass_done_o,
    output logic [WORD_W-1:0]                 glb_addr_o,
    output logic [3:0]                        glb_web_o,
    output logic [WORD_W-1:0]                 glb_wdata_o,
    output logic [WEIGHT_W-1:0]               weight_o,
    output logic [NUM_LANES-1:0]              weight_load_en_o,
    output logic [NUM_LANES-1:0]              ifmap_push_o,
    output logic [WORD_W-1:0]                 ifmap_push_data_o,
    output logic [NUM_LANES-1:0]              opsum_pop_o
);

    // phase levels and done pulses
    logic                             weight_phase;
    logic                             fill_phase;
    logic                             drain_phase;
    logic [CNT_W-1:0]                 row_idx;
    logic                             weight_done;
    logic                             fill_done;
    logic                             drain_done;

    // arbiter side
    logic                             weight_req;
    logic [WORD_W-1:0]                weight_addr;
    logic                             weight_grant;
    logic                             weight_rd_valid;
    logic [NUM_LANES-1:0]             ifmap_req;
    logic [NUM_LANES-1:0][WORD_W-1:0] ifmap_addr;
    logic [NUM_LANES-1:0]             ifmap_grant;
    logic [NUM_LANES-1:0]             ifmap_rd_valid;
    logic [NUM_LANES-1:0]             opsum_req;
    logic [NUM_LANES-1:0][WORD_W-1:0] opsum_addr;
    logic [NUM_LANES-1:0][WORD_W-1:0] opsum_data;
    logic [NUM_LANES-1:0]             opsum_grant;

    pass_ctrl i_pass_ctrl (
        .clk            (clk),
        .rst_i          (rst_i),
        .pass_start_i   (pass_start_i),
        .out_r_i        (out_r_i),
        .weight_done_i  (weight_done),
        .fill_done_i    (fill_done),
        .drain_done_i   (drain_done),
        .weight_phase_o (weight_phase),
        .fill_phase_o   (fill_phase),
        .drain_phase_o  (drain_phase),
        .row_idx_o      (row_idx),
        .pass_done_o    (pass_done_o)
    );

    weight_loader i_weight_loader (
        .clk              (clk),
        .rst_i            (rst_i),
        .weight_phase_i   (weight_phase),
        .weight_base_i    (weight_base_i),
        .grant_i          (weight_grant),
        .rd_valid_i       (weight_rd_valid),
        .glb_rdata_i      (glb_rdata_i),
        .req_o            (weight_req),
        .addr_o           (weight_addr),
        .weight_o         (weight_o),
        .weight_load_en_o (weight_load_en_o),
        .weight_done_o    (weight_done)
    );

    lane_fifo_ctrl i_lane_fifo_ctrl (
        .clk               (clk),
        .rst_i             (rst_i),
        .fill_phase_i      (fill_phase),
        .drain_phase_i     (drain_phase),
        .row_idx_i         (row_idx),
        .in_c_i            (in_c_i),
        .out_r_i           (out_r_i),
        .ifmap_base_i      (ifmap_base_i),
        .opsum_base_i      (opsum_base_i),
        .ifmap_full_i      (ifmap_full_i),
        .opsum_empty_i     (opsum_empty_i),
        .opsum_pop_data_i  (opsum_pop_data_i),
        .rd_grant_i        (ifmap_grant),
        .wr_grant_i        (opsum_grant),
        .rd_valid_i        (ifmap_rd_valid),
        .glb_rdata_i       (glb_rdata_i),
        .rd_req_o          (ifmap_req),
        .wr_req_o          (opsum_req),
        .rd_addr_o         (ifmap_addr),
        .wr_addr_o         (opsum_addr),
        .wr_data_o         (opsum_data),
        .ifmap_push_o      (ifmap_push_o),
        .ifmap_push_data_o (ifmap_push_data_o),
        .opsum_pop_o       (opsum_pop_o),
        .fill_done_o       (fill_done),
        .drain_done_o      (drain_done)
    );

    glb_arbiter i_glb_arbiter (
        .clk               (clk),
        .rst_i             (rst_i),
        .weight_req_i      (weight_req),
        .weight_addr_i     (weight_addr),
        .ifmap_req_i       (ifmap_req),
        .ifmap_addr_i      (ifmap_addr),
        .opsum_req_i       (opsum_req),
        .opsum_addr_i      (opsum_addr),
        .opsum_data_i      (opsum_data),
        .weight_grant_o    (weight_grant),
        .ifmap_grant_o     (ifmap_grant),
        .opsum_grant_o     (opsum_grant),
        .weight_rd_valid_o (weight_rd_valid),
        .ifmap_rd_valid_o  (ifmap_rd_valid),
        .glb_addr_o        (glb_addr_o),
        .glb_web_o         (glb_web_o),
        .glb_wdata_o       (glb_wdata_o)
    );

endmodule

// ==== src/token_pkg.sv ====
// --------------------
// shared sizes, GLB write-enable codes and enums for the token engine
// import with token_pkg::* in each module header
// --------------------
package token_pkg;

    localparam int NUM_LANES = 4;                  // PE / FIFO lanes, fixed
    localparam int LANE_W    = $clog2(NUM_LANES);
    localparam int WORD_W    = 32;                 // GLB data and address
    localparam int WEIGHT_W  = 8;
    localparam int CNT_W     = 8;                  // row / word counters

    // GLB byte write enables are active low
    localparam logic [3:0] WEB_READ  = 4'b1111;
    localparam logic [3:0] WEB_WRITE = 4'b0000;

    typedef enum logic [2:0] {
        PASS_IDLE,
        PASS_WEIGHT,
        PASS_FILL,
        PASS_DRAIN,
        PASS_DONE
    } pass_state_t;

    // owner of the read issued in the previous cycle
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_WEIGHT,
        SRC_IFMAP
    } glb_src_t;

endpackage

// ==== src/weight_loader.sv ====
// --------------------
// reads one weight word per lane and broadcasts its low byte
// with a one-hot load enable as each word returns
// --------------------
`timescale 1ns/1ps

module weight_loader import token_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 weight_phase_i,
    input  logic [WORD_W-1:0]    weight_base_i,
    input  logic                 grant_i,
    input  logic                 rd_valid_i,
    input  logic [WORD_W-1:0]    glb_rdata_i,
    output logic                 req_o,
    output logic [WORD_W-1:0]    addr_o,
    output logic [WEIGHT_W-1:0]  weight_o,
    output logic [NUM_LANES-1:0] weight_load_en_o,
    output logic                 weight_done_o
);

    logic [LANE_W:0]   issue_cnt;   // msb set once every lane is issued
    logic [LANE_W-1:0] ret_cnt;
    logic              in_flight;

    // one read outstanding at a time
    assign req_o  = weight_phase_i && !in_flight && !issue_cnt[LANE_W];
    assign addr_o = weight_base_i + WORD_W'(issue_cnt);

    assign weight_o         = glb_rdata_i[WEIGHT_W-1:0];
    assign weight_load_en_o = rd_valid_i ? (NUM_LANES'(1) << ret_cnt) : '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            issue_cnt     <= '0;
            ret_cnt       <= '0;
            in_flight     <= 1'b0;
            weight_done_o <= 1'b0;
        end else begin
            weight_done_o <= rd_valid_i && (ret_cnt == LANE_W'(NUM_LANES - 1));
            if (!weight_phase_i) begin
                issue_cnt <= '0;
                ret_cnt   <= '0;
                in_flight <= 1'b0;
            end else begin
                if (grant_i) begin
                    issue_cnt <= issue_cnt + 1'b1;
                    in_flight <= 1'b1;
                end
                if (rd_valid_i) begin
                    ret_cnt   <= ret_cnt + 1'b1;
                    in_flight <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== verif/tb_token_engine.sv ====
// --------------------
// token engine testbench: GLB memory, lane FIFO models, five-pass table
// build and run with make run
// --------------------
`timescale 1ns/1ps

module tb_token_engine import token_pkg::*; ();

    localparam int NUM_PASSES = 5;
    localparam int MEM_WORDS  = 1024;
    localparam int FIFO_DEPTH = 4;   // ifmap FIFO model

    // weight_base, ifmap_base, opsum_base, in_c, out_r
    int stim [NUM_PASSES][5] = '{
        '{16,  64, 512, 3, 2},
        '{32, 128, 600, 1, 3},
        '{40, 200, 640, 4, 0},   // no output rows
        '{48, 256, 700, 5, 4},
        '{ 8, 400, 800, 2, 1}
    };

    logic                             clk;
    logic                             rst_i;
    logic                             pass_start_i;
    logic [WORD_W-1:0]                weight_base_i;
    logic [WORD_W-1:0]                ifmap_base_i;
    logic [WORD_W-1:0]                opsum_base_i;
    logic [CNT_W-1:0]                 in_c_i;
    logic [CNT_W-1:0]                 out_r_i;
    logic [WORD_W-1:0]                glb_rdata_i;
    logic [NUM_LANES-1:0]             ifmap_full_i;
    logic [NUM_LANES-1:0]             opsum_empty_i;
    logic [NUM_LANES-1:0][WORD_W-1:0] opsum_pop_data_i;
    logic                             pass_done_o;
    logic [WORD_W-1:0]                glb_addr_o;
    logic [3:0]                       glb_web_o;
    logic [WORD_W-1:0]                glb_wdata_o;
    logic [WEIGHT_W-1:0]              weight_o;
    logic [NUM_LANES-1:0]             weight_load_en_o;
    logic [NUM_LANES-1:0]             ifmap_push_o;
    logic [WORD_W-1:0]                ifmap_push_data_o;
    logic [NUM_LANES-1:0]             opsum_pop_o;

    logic [WORD_W-1:0]                mem     [MEM_WORDS];   // GLB contents
    logic [WORD_W-1:0]                ref_mem [MEM_WORDS];   // contents before any write
    logic [WORD_W-1:0]                nxt_rdata;
    logic [NUM_LANES-1:0]             nxt_full;
    logic [NUM_LANES-1:0]             nxt_empty;
    logic [NUM_LANES-1:0][WORD_W-1:0] nxt_pop_data;
    logic [NUM_LANES-1:0]             full_prev;
    int occ [NUM_LANES];
    int weight_seen [NUM_LANES];
    int push_cnt [NUM_LANES];
    int pop_cnt [NUM_LANES];
    int cur_pass, cur_wb, cur_ib, cur_ob, cur_in_c, cur_out_r;
    int done_cnt, err_cnt, chk_cnt;
    int cycle_cnt, cycle_limit;
    integer seed;

    token_engine i_token_engine (.*);

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        err_cnt++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    function automatic int opsum_tag(int pass, int row, int lane);
        return pass * 256 + row * 16 + lane;
    endfunction

    // k-th word pushed on a lane over the whole pass
    function automatic int ifmap_word(int base, int in_c, int out_r, int lane, int k);
        return base + (lane * out_r + k / in_c) * in_c + k % in_c;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the passes did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // GLB and FIFO models, outputs sampled mid-cycle
    always @(negedge clk) begin
        int widx;
        if (pass_done_o)
            done_cnt++;
        if (weight_load_en_o != '0) begin
            check_equal(32'($countones(weight_load_en_o)), 32'd1, "weight enable one-hot");
            for (int l = 0; l < NUM_LANES; l++) begin
                if (weight_load_en_o[l]) begin
                    check_equal(32'(weight_o), 32'(ref_mem[cur_wb + l][7:0]),
                                $sformatf("weight byte lane %0d", l));
                    weight_seen[l]++;
                end
            end
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (ifmap_push_o[l]) begin
                if (full_prev[l])
                    report_error($sformatf("push on lane %0d after its FIFO was full", l));
                widx = ifmap_word(cur_ib, cur_in_c, cur_out_r, l, push_cnt[l]);
                check_equal(ifmap_push_data_o, ref_mem[widx % MEM_WORDS],
                            $sformatf("ifmap push lane %0d word %0d", l, push_cnt[l]));
                push_cnt[l]++;
                occ[l]++;
                if (occ[l] > FIFO_DEPTH)
                    report_error($sformatf("ifmap FIFO of lane %0d overflowed", l));
            end
            if (occ[l] > 0 && ($random(seed) & 1) != 0)
                occ[l]--;                                   // PE consumes a word
            full_prev[l] = ifmap_full_i[l];
            nxt_full[l]  = occ[l] >= FIFO_DEPTH - 1;        // one spare slot

            if (opsum_pop_o[l]) begin
                if (opsum_empty_i[l])
                    report_error($sformatf("pop on lane %0d while its FIFO was empty", l));
                check_equal(glb_addr_o, 32'((cur_ob + pop_cnt[l] * NUM_LANES + l) << 2),
                            $sformatf("opsum write address lane %0d", l));
                check_equal(glb_wdata_o, 32'(opsum_tag(cur_pass, pop_cnt[l], l)),
                            $sformatf("opsum write data lane %0d", l));
                pop_cnt[l]++;
            end
            nxt_empty[l]    = (pop_cnt[l] >= cur_out_r) || (($random(seed) & 3) == 0);
            nxt_pop_data[l] = 32'(opsum_tag(cur_pass, pop_cnt[l], l));
        end
        if ((glb_web_o == WEB_WRITE) != (opsum_pop_o != '0))
            report_error("GLB write and opsum pop did not occur together");
        if (glb_web_o == WEB_WRITE)
            mem[glb_addr_o[11:2]] = glb_wdata_o;
        else
            nxt_rdata = mem[glb_addr_o[11:2]];              // returned next cycle
    end

    always @(posedge clk) begin
        #1;
        glb_rdata_i      = nxt_rdata;
        ifmap_full_i     = nxt_full;
        opsum_empty_i    = nxt_empty;
        opsum_pop_data_i = nxt_pop_data;
    end

    task automatic run_pass(input int p);
        int done_before;
        @(posedge clk);
        #1;
        cur_pass  = p;
        cur_wb    = stim[p][0];
        cur_ib    = stim[p][1];
        cur_ob    = stim[p][2];
        cur_in_c  = stim[p][3];
        cur_out_r = stim[p][4];
        for (int l = 0; l < NUM_LANES; l++) begin
            weight_seen[l] = 0;
            push_cnt[l]    = 0;
            pop_cnt[l]     = 0;
        end
        weight_base_i = 32'(cur_wb);
        ifmap_base_i  = 32'(cur_ib);
        opsum_base_i  = 32'(cur_ob);
        in_c_i        = CNT_W'(cur_in_c);
        out_r_i       = CNT_W'(cur_out_r);
        done_before   = done_cnt;
        pass_start_i  = 1'b1;
        @(posedge clk);
        #1;
        pass_start_i = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        pass_start_i = 1'b1;   // busy, must be ignored
        @(posedge clk);
        #1;
        pass_start_i = 1'b0;
        while (done_cnt == done_before)
            @(posedge clk);
        repeat (2) @(posedge clk);   // a stretched or repeated done lands here
        check_equal(32'(done_cnt - done_before), 32'd1, "pass_done pulses");
        for (int l = 0; l < NUM_LANES; l++) begin
            check_equal(32'(weight_seen[l]), 32'd1, $sformatf("weight loads lane %0d", l));
            check_equal(32'(push_cnt[l]), 32'(cur_in_c * cur_out_r),
                        $sformatf("ifmap pushes lane %0d", l));
            check_equal(32'(pop_cnt[l]), 32'(cur_out_r), $sformatf("opsum pops lane %0d", l));
            for (int r = 0; r < cur_out_r; r++)
                check_equal(mem[cur_ob + r * NUM_LANES + l], 32'(opsum_tag(p, r, l)),
                            $sformatf("GLB opsum row %0d lane %0d", r, l));
        end
    endtask

    initial begin
        int sum;
        sum = 0;
        for (int p = 0; p < NUM_PASSES; p++)
            sum += stim[p][3] * stim[p][4] * NUM_LANES;
        cycle_limit = sum * 20 + NUM_PASSES * 100 + 50;
        cycle_cnt   = 0;
        seed        = 32'h9d8976f0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = $random(seed);
            ref_mem[i] = mem[i];
        end
        done_cnt = 0;
        err_cnt  = 0;
        chk_cnt  = 0;
        cur_pass = 0;
        cur_wb   = 0;
        cur_ib   = 0;
        cur_ob   = 0;
        cur_in_c  = 0;
        cur_out_r = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            occ[l]         = 0;
            weight_seen[l] = 0;
            push_cnt[l]    = 0;
            pop_cnt[l]     = 0;
        end
        full_prev        = '0;
        nxt_rdata        = '0;
        nxt_full         = '0;
        nxt_empty        = '1;
        nxt_pop_data     = '0;
        pass_start_i     = 1'b0;
        weight_base_i    = '0;
        ifmap_base_i     = '0;
        opsum_base_i     = '0;
        in_c_i           = '0;
        out_r_i          = '0;
        glb_rdata_i      = '0;
        ifmap_full_i     = '0;
        opsum_empty_i    = '1;
        opsum_pop_data_i = '0;
        rst_i            = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst_i = 1'b0;

        for (int p = 0; p < NUM_PASSES; p++)
            run_pass(p);

        repeat (10) @(posedge clk);   // catch a late extra done
        check_equal(32'(done_cnt), 32'(NUM_PASSES), "total pass_done count");
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
